// File: design/reg_bank.sv
//**************************************************************************
// reg_bank
// the five 24 bit control registers of the board
// takes writes from the spi receiver, answers read lookups and
// starts a 4094 chain update whenever that register is written
//**************************************************************************

module reg_bank (
  input  logic                                  cs,
  input  logic                                  arst_n,
  input  logic                                  wr_stb,
  input  spi_frame_pkg::wr_req_t                wr_req,
  input  logic [spi_frame_pkg::ADDR_BITS-1:0]   rd_addr,
  output logic [spi_frame_pkg::DATA_BITS-1:0]   rd_data,
  output reg_map_pkg::regs_t                    regs,
  output logic                                  sr_load
);

  reg_map_pkg::regs_t reg_q;

  assign regs = reg_q;

  // write decode, registers change the cycle after wr_stb
  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
    begin
      reg_q.led     <= reg_map_pkg::RST_LED;
      reg_q.spi_mux <= '0;                       // no device selected
      reg_q.sr4094  <= '0;
      reg_q.mode    <= '0;
      reg_q.direct  <= reg_map_pkg::RST_DIRECT;
      sr_load       <= 1'b0;
    end
    else
    begin
      sr_load <= 1'b0;
      if (wr_stb)
      begin
        case (wr_req.addr)
          reg_map_pkg::ADDR_LED:     reg_q.led     <= wr_req.data;
          reg_map_pkg::ADDR_SPI_MUX: reg_q.spi_mux <= wr_req.data;
          reg_map_pkg::ADDR_4094:
          begin
            reg_q.sr4094 <= wr_req.data;
            sr_load      <= 1'b1;                // driver sees the new value
          end
          reg_map_pkg::ADDR_MODE:    reg_q.mode    <= wr_req.data;
          reg_map_pkg::ADDR_DIRECT:  reg_q.direct  <= wr_req.data;
          default:;                              // unmapped, ignored
        endcase
      end
    end
  end

  // read lookup, same cycle as rd_addr
  always_comb
  begin
    case (rd_addr)
      reg_map_pkg::ADDR_LED:     rd_data = reg_q.led;
      reg_map_pkg::ADDR_SPI_MUX: rd_data = reg_q.spi_mux;
      reg_map_pkg::ADDR_4094:    rd_data = reg_q.sr4094;
      reg_map_pkg::ADDR_MODE:    rd_data = reg_q.mode;
      reg_map_pkg::ADDR_DIRECT:  rd_data = reg_q.direct;
      default:                   rd_data = reg_map_pkg::READ_DEFAULT;
    endcase
  end

endmodule

// File: design/reg_map_pkg.sv
//**************************************************************************
// reg_map_pkg
// register map of the instrument board control bank
// addresses, reset values, unmapped read pattern and the bank struct
//**************************************************************************

package reg_map_pkg;

  // register addresses, 7 bit space
  localparam logic [spi_frame_pkg::ADDR_BITS-1:0] ADDR_LED     = 7'd7;
  localparam logic [spi_frame_pkg::ADDR_BITS-1:0] ADDR_SPI_MUX = 7'd8;
  localparam logic [spi_frame_pkg::ADDR_BITS-1:0] ADDR_4094    = 7'd9;
  localparam logic [spi_frame_pkg::ADDR_BITS-1:0] ADDR_MODE    = 7'd12;
  localparam logic [spi_frame_pkg::ADDR_BITS-1:0] ADDR_DIRECT  = 7'd14;

  // alternating pattern on the leds after power up
  localparam logic [spi_frame_pkg::DATA_BITS-1:0] RST_LED    = 24'hAAAAAA;

  // bit 13 set so the relay starts in its working position
  localparam logic [spi_frame_pkg::DATA_BITS-1:0] RST_DIRECT = 24'h002000;

  // returned for any address outside the map
  localparam logic [spi_frame_pkg::DATA_BITS-1:0] READ_DEFAULT = 24'h0F0F0F;

  // all five control registers as one bundle
  typedef struct packed {
    logic [spi_frame_pkg::DATA_BITS-1:0] led;       // front panel leds
    logic [spi_frame_pkg::DATA_BITS-1:0] spi_mux;   // spi device select
    logic [spi_frame_pkg::DATA_BITS-1:0] sr4094;    // image of the 4094 chain
    logic [spi_frame_pkg::DATA_BITS-1:0] mode;
    logic [spi_frame_pkg::DATA_BITS-1:0] direct;    // direct board controls
  } regs_t;

endpackage

// File: design/spi_frame_pkg.sv
//**************************************************************************
// spi_frame_pkg
// format of the 40 bit spi frame seen by the register bank
// command byte, padding byte and 24 data bits, msb first on the wire
//**************************************************************************

package spi_frame_pkg;

  localparam int FRAME_BITS = 40;               // whole frame while ss_n is low
  localparam int DATA_BITS  = 24;               // register payload
  localparam int ADDR_BITS  = 7;                // register address
  localparam int PAD_BITS   = FRAME_BITS - DATA_BITS - ADDR_BITS - 1;

  // command flag, first bit on the wire
  localparam logic CMD_WRITE = 1'b0;

  // fields in wire order, rd is the first bit shifted in
  typedef struct packed {
    logic                 rd;                   // 0 means write
    logic [ADDR_BITS-1:0] addr;
    logic [PAD_BITS-1:0]  pad;                  // gives the bank time for the lookup
    logic [DATA_BITS-1:0] data;
  } frame_fields_t;

  // shifter view and decoded view of the same received word
  typedef union packed {
    logic [FRAME_BITS-1:0] raw;
    frame_fields_t         fields;
  } frame_u;

  // write request that travels with wr_stb
  typedef struct packed {
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] data;
  } wr_req_t;

endpackage

// File: design/spi_frame_rx.sv
//**************************************************************************
// spi_frame_rx
// spi mode 0 slave running on the system clock
// samples sclk, ss_n and mosi through synchronizers, shifts the frame in,
// asks the bank for read data after the command byte and shifts it out,
// and issues a write strobe when a full write frame has ended
//**************************************************************************

module spi_frame_rx #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic                                  cs,
  input  logic                                  arst_n,
  input  logic                                  sclk,
  input  logic                                  ss_n,
  input  logic                                  mosi,
  input  logic [spi_frame_pkg::DATA_BITS-1:0]   rd_data,
  output logic                                  miso,
  output logic                                  rd_req,
  output logic [spi_frame_pkg::ADDR_BITS-1:0]   rd_addr,
  output logic                                  wr_stb,
  output spi_frame_pkg::wr_req_t                wr_req
);

  localparam int CNT_W    = $clog2(spi_frame_pkg::FRAME_BITS + 1);
  localparam int TX_START = spi_frame_pkg::FRAME_BITS - spi_frame_pkg::DATA_BITS;

  // the three pins sampled together
  typedef struct packed {
    logic sclk;
    logic ss_n;
    logic mosi;
  } pin_t;

  localparam pin_t PIN_IDLE = '{sclk: 1'b0, ss_n: 1'b1, mosi: 1'b0};

  pin_t [SYNC_STAGES-1:0]  pin_sync;             // index 0 is the first stage
  pin_t                    pin_s;                // synchronized pins
  pin_t                    pin_d;                // one cycle older, for edges
  logic                    sclk_rise;
  logic                    sclk_fall;
  logic                    ss_rise;              // end of frame
  logic                    in_frame;
  logic [CNT_W-1:0]        bit_cnt;              // bits received, saturates
  spi_frame_pkg::frame_u   rx_frame;
  logic [spi_frame_pkg::DATA_BITS-1:0] tx_sh;    // read data, msb on miso
  logic                    tx_en;                // data phase of a frame

  assign pin_s     = pin_sync[SYNC_STAGES-1];
  assign sclk_rise = pin_s.sclk & ~pin_d.sclk;
  assign sclk_fall = ~pin_s.sclk & pin_d.sclk;
  assign ss_rise   = pin_s.ss_n & ~pin_d.ss_n;
  assign in_frame  = ~pin_s.ss_n;

  // after 8 bits the low bits of the shifter hold the address
  assign rd_addr = rx_frame.raw[spi_frame_pkg::ADDR_BITS-1:0];
  assign miso    = tx_en & tx_sh[spi_frame_pkg::DATA_BITS-1];

  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pin_sync <= {SYNC_STAGES{PIN_IDLE}};
      pin_d    <= PIN_IDLE;
    end
    else
    begin
      pin_sync <= {pin_sync[SYNC_STAGES-2:0], sclk, ss_n, mosi};
      pin_d    <= pin_s;
    end
  end

  // bit count and control strobes
  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt <= '0;
      rd_req  <= 1'b0;
      wr_stb  <= 1'b0;
      tx_en   <= 1'b0;
    end
    else
    begin
      // lookup once the 8th bit is in
      rd_req <= in_frame && sclk_rise && (bit_cnt == CNT_W'(spi_frame_pkg::ADDR_BITS));
      // only an exact length write frame reaches the bank
      wr_stb <= ss_rise && (bit_cnt == CNT_W'(spi_frame_pkg::FRAME_BITS))
                && (rx_frame.fields.rd == spi_frame_pkg::CMD_WRITE);
      if (!in_frame)
      begin
        bit_cnt <= '0;
        tx_en   <= 1'b0;
      end
      else
      begin
        if (sclk_rise && (bit_cnt != '1))
          bit_cnt <= bit_cnt + 1'b1;
        if (sclk_fall && (bit_cnt == CNT_W'(TX_START)))
          tx_en <= 1'b1;                         // bit 23 out for frame bit 16
      end
    end
  end

  // frame shifter, empty between frames
  always_ff @(posedge cs)
  begin
    if (!in_frame)
      rx_frame.raw <= '0;
    else if (sclk_rise)
      rx_frame.raw <= {rx_frame.raw[spi_frame_pkg::FRAME_BITS-2:0], pin_s.mosi};
  end

  // read data shifter, advances on falling sclk once data phase is running
  always_ff @(posedge cs)
  begin
    if (rd_req)
      tx_sh <= rd_data;
    else if (sclk_fall && (bit_cnt > CNT_W'(TX_START)))
      tx_sh <= tx_sh << 1;
  end

  always_ff @(posedge cs)
  begin
    if (ss_rise)
    begin
      wr_req.addr <= rx_frame.fields.addr;
      wr_req.data <= rx_frame.fields.data;
    end
  end

endmodule

// File: design/spi_reg_ctrl.sv
//**************************************************************************
// spi_reg_ctrl
// spi controlled register bank of the instrument board
// receiver, register bank and 4094 chain driver
//**************************************************************************

module spi_reg_ctrl #(
  parameter int unsigned SYNC_STAGES    = 2,     // pin synchronizer depth
  parameter int unsigned SR_HALF_PERIOD = 2      // 4094 clock half period in cs cycles
) (
  input  logic               cs,
  input  logic               arst_n,
  input  logic               sclk,
  input  logic               ss_n,
  input  logic               mosi,
  output logic               miso,
  output reg_map_pkg::regs_t regs,
  output logic               sr_data,
  output logic               sr_clk,
  output logic               sr_strobe,
  output logic               sr_oe_n,
  output logic               sr4094_busy
);

  logic [spi_frame_pkg::ADDR_BITS-1:0]  rd_addr;
  logic [spi_frame_pkg::DATA_BITS-1:0]  rd_data;
  logic                                 wr_stb;
  spi_frame_pkg::wr_req_t               wr_req;
  logic                                 sr_load;  // 4094 register written

  spi_frame_rx #(
    .SYNC_STAGES (SYNC_STAGES)
  ) i_spi_frame_rx (
    .cs      (cs),
    .arst_n  (arst_n),
    .sclk    (sclk),
    .ss_n    (ss_n),
    .mosi    (mosi),
    .rd_data (rd_data),
    .miso    (miso),
    .rd_req  (),
    .rd_addr (rd_addr),
    .wr_stb  (wr_stb),
    .wr_req  (wr_req)
  );

  reg_bank i_reg_bank (
    .cs      (cs),
    .arst_n  (arst_n),
    .wr_stb  (wr_stb),
    .wr_req  (wr_req),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .regs    (regs),
    .sr_load (sr_load)
  );

  sr4094_driver #(
    .SR_HALF_PERIOD (SR_HALF_PERIOD)
  ) i_sr4094_driver (
    .cs        (cs),
    .arst_n    (arst_n),
    .sr_load   (sr_load),
    .value     (regs.sr4094),                    // current value for replays
    .sr_data   (sr_data),
    .sr_clk    (sr_clk),
    .sr_strobe (sr_strobe),
    .sr_oe_n   (sr_oe_n),
    .busy      (sr4094_busy)
  );

endmodule

// File: design/sr4094_driver.sv
//**************************************************************************
// sr4094_driver
// clocks a 24 bit value msb first into a chain of 4094 shift registers,
// then strobes it into the output latches
// a load during a pass is remembered and replayed with the latest value
//**************************************************************************

module sr4094_driver #(
  parameter int unsigned SR_HALF_PERIOD = 2
) (
  input  logic                                  cs,
  input  logic                                  arst_n,
  input  logic                                  sr_load,
  input  logic [spi_frame_pkg::DATA_BITS-1:0]   value,
  output logic                                  sr_data,
  output logic                                  sr_clk,
  output logic                                  sr_strobe,
  output logic                                  sr_oe_n,
  output logic                                  busy
);

  localparam int DIV_W = $clog2(SR_HALF_PERIOD + 1);
  localparam int BIT_W = $clog2(spi_frame_pkg::DATA_BITS);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SR_HALF_PERIOD - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(spi_frame_pkg::DATA_BITS - 1);

  typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_STROBE} state_t;

  state_t             state;
  logic [DIV_W-1:0]   div_cnt;                   // half period divider
  logic [BIT_W-1:0]   bit_cnt;
  logic               pending;                   // load seen during a pass
  logic               half_done;
  logic [spi_frame_pkg::DATA_BITS-1:0] sh;       // captured value, msb next

  assign half_done = (div_cnt == DIV_LAST);
  assign busy      = (state != ST_IDLE);

  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state     <= ST_IDLE;
      div_cnt   <= '0;
      bit_cnt   <= '0;
      pending   <= 1'b0;
      sr_clk    <= 1'b0;
      sr_data   <= 1'b0;
      sr_strobe <= 1'b0;
      sr_oe_n   <= 1'b1;                         // outputs off until first latch
    end
    else
    begin
      div_cnt <= half_done ? '0 : div_cnt + 1'b1;
      case (state)
        ST_IDLE:
        begin
          div_cnt <= '0;
          if (sr_load || pending)
          begin
            state   <= ST_SHIFT;
            pending <= 1'b0;
            bit_cnt <= '0;
            sr_data <= value[spi_frame_pkg::DATA_BITS-1];
          end
        end
        ST_SHIFT:
        begin
          if (sr_load)
            pending <= 1'b1;
          if (half_done)
          begin
            sr_clk <= ~sr_clk;
            if (sr_clk && (bit_cnt == BIT_LAST))
            begin
              state     <= ST_STROBE;
              sr_data   <= 1'b0;
              sr_strobe <= 1'b1;
            end
            else if (sr_clk)
            begin
              bit_cnt <= bit_cnt + 1'b1;
              sr_data <= sh[spi_frame_pkg::DATA_BITS-2];
            end
          end
        end
        default:                                 // strobe phase
        begin
          if (sr_load)
            pending <= 1'b1;
          if (half_done)
          begin
            state     <= ST_IDLE;
            sr_strobe <= 1'b0;
            sr_oe_n   <= 1'b0;                   // chain now holds valid data
          end
        end
      endcase
    end
  end

  // capture at the start of a pass, shift after each high phase
  always_ff @(posedge cs)
  begin
    if ((state == ST_IDLE) && (sr_load || pending))
      sh <= value;
    else if ((state == ST_SHIFT) && half_done && sr_clk)
      sh <= sh << 1;
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module spi_reg_ctrl_tb -f spi_reg_ctrl.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Verification passed" \
  && echo "simulation result: pass" && exit 0 \
  || { echo "simulation result: fail"; exit 1; }

// File: spi_reg_ctrl.f
design/spi_frame_pkg.sv
design/reg_map_pkg.sv
design/spi_frame_rx.sv
design/reg_bank.sv
design/sr4094_driver.sv
design/spi_reg_ctrl.sv
test/tb_clock_gen.sv
test/spi_reg_ctrl_sva.sv
test/spi_reg_ctrl_checker.sv
test/spi_reg_ctrl_tb.sv

// File: test/spi_reg_ctrl_checker.sv
//**************************************************************************
// spi_reg_ctrl_checker
// watches miso, the register outputs, the 4094 chain pins and busy,
// keeps an expected register image and judges each finished test
//**************************************************************************

module spi_reg_ctrl_checker (
  input  logic                sclk,
  input  logic                ss_n,
  input  logic                miso,
  input  reg_map_pkg::regs_t  regs,
  input  logic                sr_data,
  input  logic                sr_clk,
  input  logic                sr_strobe,
  input  logic                sr_oe_n,
  input  logic                busy,
  input  logic                done,      // test finished and fields below valid
  input  logic [7:0]          op,
  input  logic [6:0]          addr,
  input  logic [23:0]         exp_val,
  output int                  n_pass,
  output int                  n_fail
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [39:0] miso_cap = '0;            // last 40 bits seen by the master
  logic [23:0] chain_sh = '0;            // model of the external 4094 chain
  logic [23:0] chain_latched = '0;       // chain outputs after the last strobe
  int          strobes = 0;
  int          strobes_seen = 0;
  int          n_test = 0;
  int          pass_q = 0;
  int          fail_q = 0;
  logic        test_ok;
  reg_map_pkg::regs_t shadow = '{led: reg_map_pkg::RST_LED, spi_mux: '0, sr4094: '0,
                                 mode: '0, direct: reg_map_pkg::RST_DIRECT};

  assign n_pass = pass_q;
  assign n_fail = fail_q;

  always @(posedge sclk)
    if (!ss_n)
      miso_cap <= {miso_cap[38:0], miso};   // master samples on the rising edge

  always @(posedge sr_clk)
    chain_sh <= {chain_sh[22:0], sr_data};  // msb enters first

  always @(posedge sr_strobe)
  begin
    chain_latched <= chain_sh;
    strobes       <= strobes + 1;
  end

  task automatic check_val(input string name, input logic [39:0] expv,
                           input logic [39:0] actv);
    if (actv !== expv)
    begin
      $display("mismatch %s: expected 0x%h, actual 0x%h", name, expv, actv);
      test_ok = 1'b0;
    end
  endtask

  // expected image follows the register map
  task automatic note_write(input logic [6:0] a, input logic [23:0] v);
    case (a)
      reg_map_pkg::ADDR_LED:     shadow.led     = v;
      reg_map_pkg::ADDR_SPI_MUX: shadow.spi_mux = v;
      reg_map_pkg::ADDR_4094:    shadow.sr4094  = v;
      reg_map_pkg::ADDR_MODE:    shadow.mode    = v;
      reg_map_pkg::ADDR_DIRECT:  shadow.direct  = v;
      default:;                              // unmapped address changes nothing
    endcase
  endtask

  always @(posedge done)
  begin
    test_ok = 1'b1;
    n_test++;
    if (op == "R")
      check_val("miso", {16'h0, exp_val}, miso_cap);  // bits 0 to 15 stay low
    else if (op == "W" || op == "S" || op == "X")
    begin
      if (op != "S")
        note_write(addr, exp_val);
      check_val("regs.led", {16'h0, shadow.led}, {16'h0, regs.led});
      check_val("regs.spi_mux", {16'h0, shadow.spi_mux}, {16'h0, regs.spi_mux});
      check_val("regs.sr4094", {16'h0, shadow.sr4094}, {16'h0, regs.sr4094});
      check_val("regs.mode", {16'h0, shadow.mode}, {16'h0, regs.mode});
      check_val("regs.direct", {16'h0, shadow.direct}, {16'h0, regs.direct});
    end
    else
    begin
      $display("test %0d has an unknown operation code", n_test);
      test_ok = 1'b0;
    end
    // only a 4094 write leaves its chain pass running when the test ends
    check_val("sr4094_busy", 40'((op == "W") && (addr == reg_map_pkg::ADDR_4094)),
              40'(busy));
    if (op == "X")
    begin
      if (strobes == strobes_seen)
      begin
        $display("no sr_strobe pulse followed the write to the 4094 register");
        test_ok = 1'b0;
      end
      else
        check_val("sr_data chain", {16'h0, exp_val}, {16'h0, chain_latched});
      check_val("sr_oe_n", 40'h0, 40'(sr_oe_n));    // outputs on after a latch
    end
    strobes_seen = strobes;
    if (test_ok)
      pass_q++;
    else
      fail_q++;
    $display("test %0d %c addr %h data %h: %s", n_test, op, addr, exp_val,
             test_ok ? "ok" : "error");
  end

endmodule

// File: test/spi_reg_ctrl_sva.sv
//**************************************************************************
// spi_reg_ctrl_sva
// assertions on the 4094 chain driver and on the receiver write strobe
//**************************************************************************

module spi_reg_ctrl_sva (
  input logic cs,
  input logic arst_n,
  input logic sr_load,
  input logic busy,
  input logic pending,
  input logic sr_clk,
  input logic sr_strobe,
  input logic wr_stb
);

  timeunit 1ns;
  timeprecision 100ps;

  // latch strobe only while the shift clock rests low
  strobe_clk_low: assert property (@(posedge cs) disable iff (!arst_n)
    !(sr_strobe && sr_clk))
    else $error("sr_strobe high together with sr_clk");

  // a load starts a pass or is queued for the next one
  load_busy: assert property (@(posedge cs) disable iff (!arst_n)
    sr_load |=> (busy || pending))
    else $error("sr_load neither started nor queued a chain update");

  busy_end: assert property (@(posedge cs) disable iff (!arst_n)
    $fell(busy) |-> $past(sr_strobe))        // busy only drops after the strobe
    else $error("busy dropped without a completed strobe");

  wr_one_cycle: assert property (@(posedge cs) disable iff (!arst_n)
    wr_stb |=> !wr_stb)
    else $error("wr_stb longer than one cycle");

endmodule

// File: test/spi_reg_ctrl_tb.sv
//**************************************************************************
// spi_reg_ctrl_tb
// reads the test table, bit-bangs spi frames into the register bank,
// waits for chain updates and reports the result
//**************************************************************************

module spi_reg_ctrl_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_NS    = 40;
  localparam int SR_HALF   = 10;         // long enough for a write during a pass
  localparam int SCLK_HALF = 4;          // sclk period of 8 cs cycles

  logic               cs;
  logic               arst_n;
  logic               sclk;
  logic               ss_n;
  logic               mosi;
  logic               miso;
  reg_map_pkg::regs_t regs;
  logic               sr_data;
  logic               sr_clk;
  logic               sr_strobe;
  logic               sr_oe_n;
  logic               sr4094_busy;
  logic               done;
  logic [7:0]         t_op;
  logic [6:0]         t_addr;
  logic [23:0]        t_exp;
  int                 n_pass;
  int                 n_fail;
  logic [7:0]         op_q[$];
  logic [6:0]         addr_q[$];
  logic [23:0]        data_q[$];
  logic [23:0]        exp_q[$];
  longint             limit_ns = 0;

  tb_clock_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(2)) i_clock (.cs(cs), .arst_n(arst_n));

  spi_reg_ctrl #(
    .SYNC_STAGES    (2),
    .SR_HALF_PERIOD (SR_HALF)
  ) i_spi_reg_ctrl (
    .cs (cs), .arst_n (arst_n), .sclk (sclk), .ss_n (ss_n), .mosi (mosi),
    .miso (miso), .regs (regs), .sr_data (sr_data), .sr_clk (sr_clk),
    .sr_strobe (sr_strobe), .sr_oe_n (sr_oe_n), .sr4094_busy (sr4094_busy)
  );

  spi_reg_ctrl_checker i_checker (
    .sclk (sclk), .ss_n (ss_n), .miso (miso), .regs (regs), .sr_data (sr_data),
    .sr_clk (sr_clk), .sr_strobe (sr_strobe), .sr_oe_n (sr_oe_n),
    .busy (sr4094_busy), .done (done),
    .op (t_op), .addr (t_addr), .exp_val (t_exp), .n_pass (n_pass), .n_fail (n_fail)
  );

  bind sr4094_driver spi_reg_ctrl_sva i_drv_sva (.cs(cs), .arst_n(arst_n),
    .sr_load(sr_load), .busy(busy), .pending(pending), .sr_clk(sr_clk),
    .sr_strobe(sr_strobe), .wr_stb(1'b0));
  bind spi_frame_rx spi_reg_ctrl_sva i_rx_sva (.cs(cs), .arst_n(arst_n),
    .sr_load(1'b0), .busy(1'b0), .pending(1'b0), .sr_clk(1'b0),
    .sr_strobe(1'b0), .wr_stb(wr_stb));

  task automatic step(input int n);
    repeat (n) @(posedge cs);
    #2;                                  // inputs move just after the edge
  endtask

  // mosi changes with the falling sclk in mode 0
  task automatic send_frame(input logic [39:0] word, input int nbits);
    step(1);
    ss_n = 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      mosi = word[39 - i];
      step(SCLK_HALF);
      sclk = 1'b1;
      step(SCLK_HALF);
      sclk = 1'b0;
    end
    step(SCLK_HALF);
    ss_n = 1'b1;
    mosi = 1'b0;
  endtask

  // two idle samples in a row since a replay leaves a one cycle gap in busy
  task automatic wait_driver_idle();
    int idle;
    idle = 0;
    while (idle < 2)
    begin
      step(1);
      idle = sr4094_busy ? 0 : idle + 1;
    end
  endtask

  task automatic read_tests();
    int         fd;
    int         n;
    string      line;
    logic [7:0] op;
    logic [6:0] a;
    logic [23:0] d;
    logic [23:0] e;
    fd = $fopen("test/spi_reg_ctrl_tests.txt", "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#")
        begin
          n = $sscanf(line, "%c %h %h %h", op, a, d, e);
          if (n == 4)
          begin
            op_q.push_back(op);
            addr_q.push_back(a);
            data_q.push_back(d);
            exp_q.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial
  begin
    spi_frame_pkg::frame_u frame;
    sclk   = 1'b0;
    ss_n   = 1'b1;
    mosi   = 1'b0;
    done   = 1'b0;
    t_op   = '0;
    t_addr = '0;
    t_exp  = '0;
    void'($urandom(32'h7325));
    read_tests();
    if (op_q.size() == 0)
    begin
      $display("no tests could be read from the test table");
      $display("Verification failed");
      $finish;
    end
    else
    begin
      limit_ns = longint'(op_q.size()) * (40 * 8 + 60 * SR_HALF + 100) * CLK_NS;
      wait (arst_n);
      step(2);
      foreach (op_q[i])
      begin
        frame.fields.rd   = (op_q[i] == "R");
        frame.fields.addr = addr_q[i];
        frame.fields.pad  = 8'($urandom);
        frame.fields.data = data_q[i];
        send_frame(frame.raw, (op_q[i] == "S") ? 39 : 40);  // short frame one bit less
        step(8 + int'($urandom % 16));
        if (op_q[i] == "X")
          wait_driver_idle();
        t_op   = op_q[i];
        t_addr = addr_q[i];
        t_exp  = exp_q[i];
        done   = 1'b1;
        step(1);
        done   = 1'b0;
      end
      step(2);
      $display("tests passed %0d, tests with errors %0d", n_pass, n_fail);
      if (n_fail == 0 && n_pass == op_q.size())
        $display("Verification passed");
      else
        $display("Verification failed");
      $finish;
    end
  end

  // watchdog
  initial
  begin
    wait (limit_ns != 0);
    #(limit_ns);
    $display("timeout, the tests did not finish within %0d ns", limit_ns);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: test/spi_reg_ctrl_tests.txt
# columns: op addr data expected, all hex; op W write, R read, S short write, X 4094 write
# R checks miso; W S X check the register image and X also the chain; unmapped W ignore expected
R 07 000000 AAAAAA
R 08 000000 000000
R 09 000000 000000
R 0C 000000 000000
R 0E 000000 002000
W 07 123456 123456
R 07 000000 123456
W 0C 00ABCD 00ABCD
R 0C 000000 00ABCD
R 07 000000 123456
W 08 5A0F3C 5A0F3C
R 0E 000000 002000
R 03 000000 0F0F0F
W 05 FFFFFF 000000
R 7F 000000 0F0F0F
S 08 777777 5A0F3C
R 08 000000 5A0F3C
X 09 C3A55A C3A55A
R 09 000000 C3A55A
W 09 111111 111111
X 09 5A5A5A 5A5A5A
R 09 000000 5A5A5A

// File: test/tb_clock_gen.sv
//**************************************************************************
// tb_clock_gen
// system clock and power up reset for the register bank testbench
//**************************************************************************

module tb_clock_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic cs,
  output logic arst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    cs = 1'b0;
    forever #(PERIOD_NS / 2) cs = ~cs;
  end

  // reset released just after a rising edge, like the other stimulus
  initial
  begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge cs);
    #2 arst_n = 1'b1;
  end

endmodule
